//--- hw/pcxt_glue_pkg.sv
`default_nettype none

package pcxt_glue_pkg;

	//////////////////////////////////////////////////
	// Bus and data widths
	//////////////////////////////////////////////////

	// AXI4-Lite byte address, data and response
	typedef logic [3:0]  axil_addr_t;
	typedef logic [31:0] axil_data_t;
	typedef logic [1:0]  axil_resp_t;

	localparam axil_resp_t RESP_OKAY   = 2'b00;
	localparam axil_resp_t RESP_SLVERR = 2'b10;

	// Host status word, stands in for the OSD status bus
	typedef logic [31:0] status_word_t;

	// Bit positions inside the status word
	localparam int STATUS_SOFT_RESET  = 0;
	localparam int STATUS_SPLASH_SKIP = 7;
	localparam int STATUS_ASPECT_LO   = 8;
	localparam int STATUS_MOUNT_RESET = 14;

	// One HDMI aspect output, bit 12 selects scaled size
	typedef logic [12:0] aspect_t;

	// Mounted image size in bytes
	typedef logic [63:0] img_size_t;

	// Reset sequencer states
	typedef enum logic [1:0] {
		RST_HOLD,
		RST_SYS_STRETCH,
		RST_CPU_DELAY,
		RST_RUN
	} reset_state_t;

	// Register map
	localparam axil_addr_t REG_STATUS = 4'h0;
	localparam axil_addr_t REG_INFO   = 4'h4;

	//////////////////////////////////////////////////
	// Default timing values
	//////////////////////////////////////////////////
	localparam int DEF_CLK_HZ           = 50_000_000;
	localparam int DEF_SAMPLE_HZ        = 44100;
	localparam int DEF_POR_CYCLES       = 65535;
	localparam int DEF_CPU_RESET_CYCLES = 42;
	localparam int DEF_SPLASH_SECONDS   = 5;
	localparam int DEF_LED_HOLD_CYCLES  = 4_500_000;

endpackage

`default_nettype wire

//--- hw/cfg_regs.sv
`default_nettype none

module cfg_regs import pcxt_glue_pkg::*; (
	input  wire               CLK_50M,
	input  wire               reset_wire,
	// AXI4-Lite, master side
	input  wire               awvalid,
	input  wire axil_addr_t   awaddr,
	input  wire               wvalid,
	input  wire axil_data_t   wdata,
	input  wire               bready,
	input  wire               arvalid,
	input  wire axil_addr_t   araddr,
	input  wire               rready,
	// AXI4-Lite, slave side
	output logic              awready,
	output logic              wready,
	output logic              bvalid,
	output axil_resp_t        bresp,
	output logic              arready,
	output logic              rvalid,
	output axil_data_t        rdata,
	output axil_resp_t        rresp,
	// Readback flags
	input  wire               sys_reset,
	input  wire               cpu_reset,
	input  wire               splash_active,
	input  wire               vsd_present,
	// Decoded outputs
	output status_word_t      status_word,
	output aspect_t           video_arx,
	output aspect_t           video_ary
);

	logic       wr_fire;
	logic       rd_fire;
	logic       wr_hit;
	axil_data_t info_word;
	axil_data_t rd_data;
	axil_resp_t rd_resp;
	logic [1:0] aspect_sel;

	//////////////////////////////////////////////////
	// Handshakes
	//////////////////////////////////////////////////

	// Address and data accepted together, one write in flight
	assign wr_fire = awvalid & wvalid & ~bvalid;
	assign awready = wr_fire;
	assign wready  = wr_fire;
	// Only the status word is writable
	assign wr_hit  = (awaddr == REG_STATUS);

	// New read only once the previous data has gone
	assign rd_fire = arvalid & ~rvalid;
	assign arready = rd_fire;

	// Live machine state for the host
	assign info_word = {28'd0, vsd_present, splash_active, cpu_reset, sys_reset};

	// Read decode, unmapped offsets give zero with an error
	always_comb begin
		rd_data = '0;
		rd_resp = RESP_OKAY;
		case (araddr)
			REG_STATUS: rd_data = status_word;
			REG_INFO:   rd_data = info_word;
			default:    rd_resp = RESP_SLVERR;
		endcase
	end

	// Control state
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			status_word <= '0;
			bvalid      <= 1'b0;
			rvalid      <= 1'b0;
		end else begin
			if (wr_fire) begin
				bvalid <= 1'b1;
				if (wr_hit)
					status_word <= wdata;
			end else if (bready) begin
				bvalid <= 1'b0;
			end
			// Response held until the master takes it
			if (rd_fire)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

	// Response payload
	always_ff @(posedge CLK_50M) begin
		if (wr_fire)
			bresp <= wr_hit ? RESP_OKAY : RESP_SLVERR;
		if (rd_fire) begin
			rdata <= rd_data;
			rresp <= rd_resp;
		end
	end

	//////////////////////////////////////////////////
	// Aspect ratio decode
	//////////////////////////////////////////////////

	// Zero means original 4:3, else the ARC index
	assign aspect_sel = status_word[STATUS_ASPECT_LO +: 2];
	assign video_arx  = (aspect_sel == 2'd0) ? aspect_t'(4) : aspect_t'(aspect_sel - 2'd1);
	assign video_ary  = (aspect_sel == 2'd0) ? aspect_t'(3) : aspect_t'(0);

endmodule

`default_nettype wire

//--- hw/reset_sequencer.sv
`default_nettype none

module reset_sequencer import pcxt_glue_pkg::*; #(
	parameter int POR_CYCLES       = DEF_POR_CYCLES,
	parameter int CPU_RESET_CYCLES = DEF_CPU_RESET_CYCLES
) (
	input  wire               CLK_50M,
	input  wire               reset_wire,
	input  wire               pll_locked,
	input  wire               user_button,
	input  wire status_word_t status_word,
	input  wire               img_mounted,
	input  wire               splash_active,
	output logic              sys_reset,
	output logic              cpu_reset
);

	// One counter serves both delays
	localparam int CNT_MAX = (POR_CYCLES > CPU_RESET_CYCLES) ? POR_CYCLES : CPU_RESET_CYCLES;
	localparam int CNT_W   = $clog2(CNT_MAX + 1);

	reset_state_t     state;
	logic [CNT_W-1:0] cnt;
	logic             hold;

	//////////////////////////////////////////////////
	// Reset sources
	//////////////////////////////////////////////////

	// Any of these keeps the machine parked
	assign hold = reset_wire
		| status_word[STATUS_SOFT_RESET]
		| user_button
		| ~pll_locked
		| (status_word[STATUS_MOUNT_RESET] & img_mounted)
		| splash_active;

	// Raised by a source at once, released by the FSM
	assign sys_reset = hold | (state == RST_HOLD) | (state == RST_SYS_STRETCH);
	assign cpu_reset = hold | (state != RST_RUN);

	//////////////////////////////////////////////////
	// Release sequence
	//////////////////////////////////////////////////
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			state <= RST_HOLD;
			cnt   <= '0;
		end else if (hold) begin
			// New source restarts the whole sequence
			state <= RST_HOLD;
			cnt   <= '0;
		end else begin
			case (state)
				RST_HOLD: begin
					// First quiet cycle already counts
					state <= RST_SYS_STRETCH;
					cnt   <= CNT_W'(1);
				end
				RST_SYS_STRETCH: begin
					if (cnt >= CNT_W'(POR_CYCLES - 1)) begin
						state <= RST_CPU_DELAY;
						cnt   <= CNT_W'(1);
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				RST_CPU_DELAY: begin
					// CPU comes out of reset after the chipset
					if (cnt >= CNT_W'(CPU_RESET_CYCLES))
						state <= RST_RUN;
					else
						cnt <= cnt + 1'b1;
				end
				default: state <= RST_RUN;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hw/sample_tick_gen.sv
`default_nettype none

module sample_tick_gen import pcxt_glue_pkg::*; #(
	parameter int CLK_HZ    = DEF_CLK_HZ,
	parameter int SAMPLE_HZ = DEF_SAMPLE_HZ
) (
	input  wire  CLK_50M,
	input  wire  reset_wire,
	output logic sample_tick
);

	// Room for one full period plus one step
	localparam int ACC_W = $clog2(CLK_HZ + SAMPLE_HZ + 1);

	logic [ACC_W-1:0] acc;
	logic [ACC_W-1:0] acc_sum;

	// Phase after this cycle's step
	assign acc_sum = acc + ACC_W'(SAMPLE_HZ);

	// Fractional divider, remainder carried into the next period
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			acc         <= '0;
			sample_tick <= 1'b0;
		end else if (acc_sum >= ACC_W'(CLK_HZ)) begin
			acc         <= acc_sum - ACC_W'(CLK_HZ);
			sample_tick <= 1'b1;
		end else begin
			acc         <= acc_sum;
			sample_tick <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- hw/splash_timer.sv
`default_nettype none

module splash_timer import pcxt_glue_pkg::*; #(
	parameter int SPLASH_SECONDS   = DEF_SPLASH_SECONDS,
	parameter int TICKS_PER_SECOND = DEF_CLK_HZ
) (
	input  wire               CLK_50M,
	input  wire               reset_wire,
	input  wire status_word_t status_word,
	output logic              splash_active
);

	localparam int TICK_W = $clog2(TICKS_PER_SECOND + 1);
	localparam int SEC_W  = $clog2(SPLASH_SECONDS + 1);

	logic [TICK_W-1:0] tick_cnt;
	logic [SEC_W-1:0]  sec_cnt;
	logic              second_done;
	logic              skip_req;

	// Last cycle of the current second
	assign second_done = (tick_cnt == TICK_W'(TICKS_PER_SECOND - 1));
	// Host asked to skip the logo
	assign skip_req    = status_word[STATUS_SPLASH_SKIP];

	//////////////////////////////////////////////////
	// Splash countdown
	//////////////////////////////////////////////////
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			splash_active <= 1'b1;
			tick_cnt      <= '0;
			sec_cnt       <= '0;
		end else if (splash_active) begin
			if (skip_req) begin
				splash_active <= 1'b0;
			end else if (second_done) begin
				tick_cnt <= '0;
				sec_cnt  <= sec_cnt + 1'b1;
				// Last second elapsed
				if (sec_cnt == SEC_W'(SPLASH_SECONDS - 1))
					splash_active <= 1'b0;
			end else begin
				tick_cnt <= tick_cnt + 1'b1;
			end
		end
		// Once ended, stays off until the next board reset
	end

endmodule

`default_nettype wire

//--- hw/sd_spi_router.sv
`default_nettype none

module sd_spi_router import pcxt_glue_pkg::*; (
	input  wire            CLK_50M,
	input  wire            reset_wire,
	input  wire            img_mounted,
	input  wire img_size_t img_size,
	// SPI from the core
	input  wire            spi_cs,
	input  wire            spi_sck,
	input  wire            spi_mosi,
	output logic           spi_miso,
	// Physical card
	input  wire            sd_miso,
	output logic           sd_cs,
	output logic           sd_sck,
	output logic           sd_mosi,
	// Virtual disk
	input  wire            vsd_miso,
	output logic           vsd_cs,
	output logic           vsd_sck,
	output logic           vsd_mosi,
	output logic           vsd_present
);

	// Mount event tells whether an image is present
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire)
			vsd_present <= 1'b0;
		else if (img_mounted)
			vsd_present <= |img_size;
	end

	//////////////////////////////////////////////////
	// SPI steering
	//////////////////////////////////////////////////

	// Card parked deselected while an image is mounted
	assign sd_cs    = spi_cs | vsd_present;
	assign sd_sck   = spi_sck & ~vsd_present;
	assign sd_mosi  = spi_mosi & ~vsd_present;

	// Virtual disk parked otherwise
	assign vsd_cs   = spi_cs | ~vsd_present;
	assign vsd_sck  = spi_sck & vsd_present;
	assign vsd_mosi = spi_mosi & vsd_present;

	// Return data from whichever target is live
	assign spi_miso = vsd_present ? vsd_miso : sd_miso;

endmodule

`default_nettype wire

//--- hw/led_stretcher.sv
`default_nettype none

module led_stretcher import pcxt_glue_pkg::*; #(
	parameter int LED_HOLD_CYCLES = DEF_LED_HOLD_CYCLES
) (
	input  wire  CLK_50M,
	input  wire  reset_wire,
	input  wire  activity,
	output logic led_user
);

	localparam int CNT_W = $clog2(LED_HOLD_CYCLES + 1);

	logic [CNT_W-1:0] hold_cnt;

	// Each busy cycle restarts the hold time
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire)
			hold_cnt <= '0;
		else if (activity)
			hold_cnt <= CNT_W'(LED_HOLD_CYCLES);
		else if (hold_cnt != '0)
			hold_cnt <= hold_cnt - 1'b1;
	end

	// Lit while time remains
	assign led_user = (hold_cnt != '0);

endmodule

`default_nettype wire

//--- hw/pcxt_glue_top.sv
`default_nettype none

module pcxt_glue_top import pcxt_glue_pkg::*; #(
	parameter int CLK_HZ           = DEF_CLK_HZ,
	parameter int SAMPLE_HZ        = DEF_SAMPLE_HZ,
	parameter int POR_CYCLES       = DEF_POR_CYCLES,
	parameter int CPU_RESET_CYCLES = DEF_CPU_RESET_CYCLES,
	parameter int SPLASH_SECONDS   = DEF_SPLASH_SECONDS,
	parameter int TICKS_PER_SECOND = DEF_CLK_HZ,
	parameter int LED_HOLD_CYCLES  = DEF_LED_HOLD_CYCLES
) (
	input  wire             CLK_50M,
	input  wire             reset_wire,
	input  wire             pll_locked,
	input  wire             user_button,
	// AXI4-Lite from the host
	input  wire             awvalid,
	input  wire axil_addr_t awaddr,
	input  wire             wvalid,
	input  wire axil_data_t wdata,
	input  wire             bready,
	input  wire             arvalid,
	input  wire axil_addr_t araddr,
	input  wire             rready,
	output logic            awready,
	output logic            wready,
	output logic            bvalid,
	output axil_resp_t      bresp,
	output logic            arready,
	output logic            rvalid,
	output axil_data_t      rdata,
	output axil_resp_t      rresp,
	// Image mount
	input  wire             img_mounted,
	input  wire img_size_t  img_size,
	// Core SPI and its two targets
	input  wire             spi_cs,
	input  wire             spi_sck,
	input  wire             spi_mosi,
	output logic            spi_miso,
	input  wire             sd_miso,
	output logic            sd_cs,
	output logic            sd_sck,
	output logic            sd_mosi,
	input  wire             vsd_miso,
	output logic            vsd_cs,
	output logic            vsd_sck,
	output logic            vsd_mosi,
	// Machine outputs
	output aspect_t         video_arx,
	output aspect_t         video_ary,
	output logic            sys_reset,
	output logic            cpu_reset,
	output logic            sample_tick,
	output logic            led_user
);

	status_word_t status_word;
	logic         splash_active;
	logic         vsd_present;

	//////////////////////////////////////////////////
	// Host registers
	//////////////////////////////////////////////////
	cfg_regs u_cfg_regs (
		.CLK_50M       (CLK_50M),
		.reset_wire    (reset_wire),
		.awvalid       (awvalid),
		.awaddr        (awaddr),
		.wvalid        (wvalid),
		.wdata         (wdata),
		.bready        (bready),
		.arvalid       (arvalid),
		.araddr        (araddr),
		.rready        (rready),
		.awready       (awready),
		.wready        (wready),
		.bvalid        (bvalid),
		.bresp         (bresp),
		.arready       (arready),
		.rvalid        (rvalid),
		.rdata         (rdata),
		.rresp         (rresp),
		.sys_reset     (sys_reset),
		.cpu_reset     (cpu_reset),
		.splash_active (splash_active),
		.vsd_present   (vsd_present),
		.status_word   (status_word),
		.video_arx     (video_arx),
		.video_ary     (video_ary)
	);

	//////////////////////////////////////////////////
	// Reset chain
	//////////////////////////////////////////////////
	reset_sequencer #(
		.POR_CYCLES       (POR_CYCLES),
		.CPU_RESET_CYCLES (CPU_RESET_CYCLES)
	) u_reset_sequencer (
		.CLK_50M       (CLK_50M),
		.reset_wire    (reset_wire),
		.pll_locked    (pll_locked),
		.user_button   (user_button),
		.status_word   (status_word),
		.img_mounted   (img_mounted),
		.splash_active (splash_active),
		.sys_reset     (sys_reset),
		.cpu_reset     (cpu_reset)
	);

	// Logo time holds the machine in reset
	splash_timer #(
		.SPLASH_SECONDS   (SPLASH_SECONDS),
		.TICKS_PER_SECOND (TICKS_PER_SECOND)
	) u_splash_timer (
		.CLK_50M       (CLK_50M),
		.reset_wire    (reset_wire),
		.status_word   (status_word),
		.splash_active (splash_active)
	);

	//////////////////////////////////////////////////
	// Audio, storage and LED
	//////////////////////////////////////////////////
	sample_tick_gen #(
		.CLK_HZ    (CLK_HZ),
		.SAMPLE_HZ (SAMPLE_HZ)
	) u_sample_tick_gen (
		.CLK_50M     (CLK_50M),
		.reset_wire  (reset_wire),
		.sample_tick (sample_tick)
	);

	sd_spi_router u_sd_spi_router (
		.CLK_50M     (CLK_50M),
		.reset_wire  (reset_wire),
		.img_mounted (img_mounted),
		.img_size    (img_size),
		.spi_cs      (spi_cs),
		.spi_sck     (spi_sck),
		.spi_mosi    (spi_mosi),
		.spi_miso    (spi_miso),
		.sd_miso     (sd_miso),
		.sd_cs       (sd_cs),
		.sd_sck      (sd_sck),
		.sd_mosi     (sd_mosi),
		.vsd_miso    (vsd_miso),
		.vsd_cs      (vsd_cs),
		.vsd_sck     (vsd_sck),
		.vsd_mosi    (vsd_mosi),
		.vsd_present (vsd_present)
	);

	// Disk access whenever the core selects a device
	led_stretcher #(
		.LED_HOLD_CYCLES (LED_HOLD_CYCLES)
	) u_led_stretcher (
		.CLK_50M    (CLK_50M),
		.reset_wire (reset_wire),
		.activity   (~spi_cs),
		.led_user   (led_user)
	);

endmodule

`default_nettype wire

//--- sim/tb_axil_tasks.svh
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

//////////////////////////////////////////////////
// AXI4-Lite master driven 2 ns after the edge
//////////////////////////////////////////////////

// Address and data together and response after a random stall
task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
		output axil_resp_t resp);
	int   n;
	int   stall;
	logic hs;
	resp    = RESP_SLVERR;
	awaddr  = addr;
	wdata   = data;
	awvalid = 1'b1;
	wvalid  = 1'b1;
	n       = 0;
	hs      = 1'b0;
	// Combinational ready sampled just before the edge
	while (!hs && n < WAIT_MAX) begin
		#1;
		hs = awready & wready;
		tick();
		n++;
	end
	if (!hs)
		note_timeout("write address/data handshake");
	// Edge where the register took the data
	wr_hs_cyc = cyc;
	// Pending response blocks a second handshake
	check_val("bvalid", 64'(bvalid), 64'(1));
	check_val("awready", 64'(awready), 64'(0));
	check_val("wready", 64'(wready), 64'(0));
	awvalid   = 1'b0;
	wvalid    = 1'b0;
	stall     = int'(next_random() >> 30);
	repeat (stall) tick();
	bready = 1'b1;
	hs     = 1'b0;
	n      = 0;
	while (!hs && n < WAIT_MAX) begin
		#1;
		hs   = bvalid;
		resp = bresp;
		tick();
		n++;
	end
	if (!hs)
		note_timeout("write response");
	bready = 1'b0;
endtask

// Address phase and data after a random stall
task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
		output axil_resp_t resp);
	int   n;
	int   stall;
	logic hs;
	data    = '0;
	resp    = RESP_SLVERR;
	araddr  = addr;
	arvalid = 1'b1;
	n       = 0;
	hs      = 1'b0;
	while (!hs && n < WAIT_MAX) begin
		#1;
		hs = arready;
		tick();
		n++;
	end
	if (!hs)
		note_timeout("read address handshake");
	// Data one cycle after the address handshake
	check_val("rvalid", 64'(rvalid), 64'(1));
	check_val("arready", 64'(arready), 64'(0));
	arvalid = 1'b0;
	stall   = int'(next_random() >> 30);
	repeat (stall) tick();
	rready = 1'b1;
	hs     = 1'b0;
	n      = 0;
	while (!hs && n < WAIT_MAX) begin
		#1;
		hs   = rvalid;
		data = rdata;
		resp = rresp;
		tick();
		n++;
	end
	if (!hs)
		note_timeout("read data");
	rready = 1'b0;
endtask

`endif

//--- sim/tb_pcxt_glue.sv
`default_nettype none

module tb_pcxt_glue import pcxt_glue_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	// Shortened timing for simulation
	localparam int POR      = 20;
	localparam int CPU_DLY  = 6;
	localparam int SPLASH_S = 3;
	localparam int TPS      = 50;
	localparam int LED_HOLD = 30;
	localparam int WAIT_MAX = 1000;
	localparam int WINDOW   = 20000;

	logic CLK_50M;
	logic reset_wire;
	logic pll_locked;
	logic user_button;
	logic awvalid, wvalid, bready, arvalid, rready;
	axil_addr_t awaddr, araddr;
	axil_data_t wdata, rdata;
	logic awready, wready, bvalid, arready, rvalid;
	axil_resp_t bresp, rresp;
	logic img_mounted;
	img_size_t img_size;
	logic spi_cs, spi_sck, spi_mosi, spi_miso, sd_miso, vsd_miso;
	logic sd_cs, sd_sck, sd_mosi, vsd_cs, vsd_sck, vsd_mosi;
	aspect_t video_arx, video_ary;
	logic sys_reset, cpu_reset, sample_tick, led_user;

	int checks = 0;
	int errors = 0;
	int timeouts = 0;
	int cyc = 0;
	int wr_hs_cyc = 0;
	logic [31:0] lcg_state = 32'h9e83;

	pcxt_glue_top #(
		.POR_CYCLES       (POR),
		.CPU_RESET_CYCLES (CPU_DLY),
		.SPLASH_SECONDS   (SPLASH_S),
		.TICKS_PER_SECOND (TPS),
		.LED_HOLD_CYCLES  (LED_HOLD)
	) dut (.*);

	//////////////////////////////////////////////////
	// Clock, edge counter and helpers
	//////////////////////////////////////////////////
	initial begin
		CLK_50M = 1'b0;
		forever #10 CLK_50M = ~CLK_50M;
	end

	// Number of the last rising edge
	always @(posedge CLK_50M)
		cyc <= cyc + 1;

	task automatic tick();
		@(posedge CLK_50M);
		#2;
	endtask

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("[FAIL] %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic note_timeout(input string what);
		timeouts++;
		$display("Timed out at %0t ns while waiting for %s", $time, what);
	endtask

	task automatic finish_run();
		$display("Summary: %0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	endtask

	`include "tb_axil_tasks.svh"

	// Sys release counted from the last active source edge, CPU after that
	task automatic check_release(input string src, input int start, input int sys_dly);
		int n;
		int sys_cyc;
		n = 0;
		while (sys_reset && n < WAIT_MAX) begin
			tick();
			n++;
		end
		if (sys_reset)
			note_timeout({src, " sys_reset release"});
		sys_cyc = cyc;
		check_val({src, " sys_reset delay"}, 64'(sys_cyc - start), 64'(sys_dly));
		n = 0;
		while (cpu_reset && n < WAIT_MAX) begin
			tick();
			n++;
		end
		if (cpu_reset)
			note_timeout({src, " cpu_reset release"});
		check_val({src, " cpu_reset delay"}, 64'(cyc - sys_cyc), 64'(CPU_DLY));
	endtask

	// Random core SPI levels against the selected target
	task automatic route_check(input logic vsd);
		logic [31:0] r;
		repeat (8) begin
			r        = next_random();
			spi_cs   = r[31];
			spi_sck  = r[30];
			spi_mosi = r[29];
			sd_miso  = r[28];
			vsd_miso = r[27];
			#1;
			check_val("sd_cs", 64'(sd_cs), 64'(vsd ? 1'b1 : spi_cs));
			check_val("sd_sck", 64'(sd_sck), 64'(vsd ? 1'b0 : spi_sck));
			check_val("sd_mosi", 64'(sd_mosi), 64'(vsd ? 1'b0 : spi_mosi));
			check_val("vsd_cs", 64'(vsd_cs), 64'(vsd ? spi_cs : 1'b1));
			check_val("vsd_sck", 64'(vsd_sck), 64'(vsd ? spi_sck : 1'b0));
			check_val("vsd_mosi", 64'(vsd_mosi), 64'(vsd ? spi_mosi : 1'b0));
			check_val("spi_miso", 64'(spi_miso), 64'(vsd ? vsd_miso : sd_miso));
			tick();
		end
	endtask

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////
	initial begin
		axil_resp_t resp;
		axil_data_t data;
		axil_data_t last;
		int start;
		int n;
		int cnt;
		int lo;
		int act;
		reset_wire  = 1'b1;
		pll_locked  = 1'b1;
		user_button = 1'b0;
		awvalid     = 1'b0;
		awaddr      = '0;
		wvalid      = 1'b0;
		wdata       = '0;
		bready      = 1'b0;
		arvalid     = 1'b0;
		araddr      = '0;
		rready      = 1'b0;
		img_mounted = 1'b0;
		img_size    = '0;
		spi_cs      = 1'b1;
		spi_sck     = 1'b0;
		spi_mosi    = 1'b0;
		sd_miso     = 1'b0;
		vsd_miso    = 1'b0;
		repeat (10) tick();
		// Idle levels while reset is held
		check_val("bvalid", 64'(bvalid), 64'(0));
		check_val("rvalid", 64'(rvalid), 64'(0));
		check_val("sample_tick", 64'(sample_tick), 64'(0));
		check_val("led_user", 64'(led_user), 64'(0));
		check_val("sys_reset", 64'(sys_reset), 64'(1));
		check_val("cpu_reset", 64'(cpu_reset), 64'(1));
		check_val("sd_cs", 64'(sd_cs), 64'(1));
		reset_wire = 1'b0;
		start = cyc;

		// Splash runs, both resets and splash flagged, no image
		axil_read(REG_INFO, data, resp);
		check_val("REG_INFO", 64'(data), 64'(32'h7));
		check_val("rresp", 64'(resp), 64'(RESP_OKAY));
		check_release("splash", start, SPLASH_S * TPS + POR);
		axil_read(REG_INFO, data, resp);
		check_val("REG_INFO", 64'(data), 64'(0));

		// Status word readback under random stalls
		last = '0;
		repeat (8) begin
			last = next_random();
			axil_write(REG_STATUS, last, resp);
			check_val("bresp", 64'(resp), 64'(RESP_OKAY));
			axil_read(REG_STATUS, data, resp);
			check_val("REG_STATUS", 64'(data), 64'(last));
			check_val("rresp", 64'(resp), 64'(RESP_OKAY));
		end
		// Read-only and unmapped writes are refused
		axil_write(REG_INFO, next_random(), resp);
		check_val("bresp", 64'(resp), 64'(RESP_SLVERR));
		axil_write(axil_addr_t'(8), next_random(), resp);
		check_val("bresp", 64'(resp), 64'(RESP_SLVERR));
		axil_read(REG_STATUS, data, resp);
		check_val("REG_STATUS", 64'(data), 64'(last));
		axil_read(axil_addr_t'(8), data, resp);
		check_val("rresp", 64'(resp), 64'(RESP_SLVERR));
		check_val("rdata", 64'(data), 64'(0));

		// Aspect index, zero gives 4:3
		for (int s = 0; s < 4; s++) begin
			axil_write(REG_STATUS, axil_data_t'(s) << STATUS_ASPECT_LO, resp);
			check_val("video_arx", 64'(video_arx), 64'((s == 0) ? 4 : s - 1));
			check_val("video_ary", 64'(video_ary), 64'((s == 0) ? 3 : 0));
		end
		axil_write(REG_STATUS, '0, resp);
		n = 0;
		while (cpu_reset && n < WAIT_MAX) begin
			tick();
			n++;
		end
		if (cpu_reset)
			note_timeout("cpu_reset release before the source tests");

		// Soft reset bit
		axil_write(REG_STATUS, axil_data_t'(1) << STATUS_SOFT_RESET, resp);
		check_val("sys_reset", 64'(sys_reset), 64'(1));
		check_val("cpu_reset", 64'(cpu_reset), 64'(1));
		axil_write(REG_STATUS, '0, resp);
		check_release("soft reset", wr_hs_cyc, POR);
		// Button press
		user_button = 1'b1;
		#1;
		check_val("sys_reset", 64'(sys_reset), 64'(1));
		check_val("cpu_reset", 64'(cpu_reset), 64'(1));
		repeat (3) tick();
		user_button = 1'b0;
		check_release("user_button", cyc, POR);
		// PLL loses lock
		pll_locked = 1'b0;
		#1;
		check_val("sys_reset", 64'(sys_reset), 64'(1));
		check_val("cpu_reset", 64'(cpu_reset), 64'(1));
		repeat (3) tick();
		pll_locked = 1'b1;
		check_release("pll_locked", cyc, POR);

		// Image mounted, virtual disk takes the bus
		img_size    = {next_random(), next_random()} | 64'h1;
		img_mounted = 1'b1;
		tick();
		img_mounted = 1'b0;
		axil_read(REG_INFO, data, resp);
		check_val("REG_INFO", 64'(data), 64'(32'h8));
		route_check(1'b1);
		// Empty image hands the bus back to the card
		img_size    = '0;
		img_mounted = 1'b1;
		tick();
		img_mounted = 1'b0;
		axil_read(REG_INFO, data, resp);
		check_val("REG_INFO", 64'(data), 64'(0));
		route_check(1'b0);
		spi_cs = 1'b1;

		// Sample rate over a fixed window
		cnt = 0;
		repeat (WINDOW) begin
			tick();
			if (sample_tick)
				cnt++;
		end
		lo = int'(64'(WINDOW) * 64'(DEF_SAMPLE_HZ) / 64'(DEF_CLK_HZ));
		checks++;
		assert (cnt >= lo && cnt <= lo + 1) else begin
			errors++;
			$display("[FAIL] %0t ns: sample_tick count = %0d, expected %0d or %0d",
				$time, cnt, lo, lo + 1);
		end

		// LED retriggered, then timed from the last access
		n = 0;
		while (led_user && n < WAIT_MAX) begin
			tick();
			n++;
		end
		if (led_user)
			note_timeout("led_user to go dark");
		act = cyc;
		repeat (3) begin
			spi_cs = 1'b0;
			tick();
			act    = cyc;
			spi_cs = 1'b1;
			check_val("led_user", 64'(led_user), 64'(1));
			repeat (int'(next_random() >> 28)) tick();
		end
		n = 0;
		while (led_user && n < WAIT_MAX) begin
			tick();
			n++;
		end
		if (led_user)
			note_timeout("led_user hold to expire");
		check_val("led_user hold", 64'(cyc - act), 64'(LED_HOLD));

		finish_run();
	end

	// Last resort against a stuck run
	initial begin
		#2_000_000;
		note_timeout("the end of the run");
		finish_run();
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+sim
hw/pcxt_glue_pkg.sv
hw/cfg_regs.sv
hw/reset_sequencer.sv
hw/sample_tick_gen.sv
hw/splash_timer.sv
hw/sd_spi_router.sv
hw/led_stretcher.sv
hw/pcxt_glue_top.sv
sim/tb_pcxt_glue.sv

//--- Makefile
# Verilator build and run for the PC/XT glue logic

VERILATOR ?= verilator
TOP       ?= tb_pcxt_glue
RTL_TOP   ?= pcxt_glue_top
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert --timescale $(TIMESCALE)
LINTFLAGS ?= --lint-only --timing --timescale $(TIMESCALE)
FAIL_MSG  ?= TEST FAILED
PASS_MSG  ?= TEST OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@! grep -q "$(FAIL_MSG)" $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
